//--- Bender.yml
package:
  name: fft_twdl

sources:
  - files:
      - verilog/fft_twdl_pkg.sv
      - verilog/twdl_data_fifo.sv
      - verilog/twdl_cordic.sv
      - verilog/twdl_power_gen.sv
      - verilog/twdl_rotator.sv
      - verilog/fft_twdl_top.sv
  - target: test
    files:
      - verification/tb_fft_twdl.sv

//--- sim.f
verilog/fft_twdl_pkg.sv
verilog/twdl_data_fifo.sv
verilog/twdl_cordic.sv
verilog/twdl_power_gen.sv
verilog/twdl_rotator.sv
verilog/fft_twdl_top.sv
verification/tb_fft_twdl.sv

//--- verification/tb_fft_twdl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fft_twdl import fft_twdl_pkg::*;;

	localparam int w_data = 18;
	localparam int w_addr = 8;
	localparam int depth = 32;
	localparam int n_cases = 8;
	localparam int rot_tol = 3;
	localparam longint half_lsb = 1 << (tw_frac - 1);
	localparam real pi = 3.14159265358979;

	logic clk;
	logic rst_n;
	logic [2:0] factor;
	logic [w_ratio-1:0] twdl_num;
	logic [w_ratio-1:0] twdl_den;
	logic in_val;
	logic [w_addr-1:0] in_addr;
	logic signed [w_data-1:0] din_real [n_lanes];
	logic signed [w_data-1:0] din_imag [n_lanes];
	logic out_val;
	logic [w_addr-1:0] out_addr;
	logic signed [w_data-1:0] dout_real [n_lanes];
	logic signed [w_data-1:0] dout_imag [n_lanes];

	// case table with factor, ratio, beat count, gap mask and expected latency
	int tab_factor [n_cases];
	int tab_num [n_cases];
	int tab_den [n_cases];
	int tab_beats [n_cases];
	logic [7:0] tab_gaps [n_cases];
	int tab_lat [n_cases];

	// one entry per beat in flight
	int due_q [$];
	logic [w_addr-1:0] addr_q [$];
	logic [n_lanes-1:0][w_data-1:0] re_q [$];
	logic [n_lanes-1:0][w_data-1:0] im_q [$];
	logic [n_lanes-1:0] exact_q [$];

	int seed = 32'hd0ae;
	int cycle = 0;
	int cycle_limit = 0;
	logic [w_addr-1:0] next_addr = '0;

	fft_twdl_top #(
		.w_data (w_data),
		.w_addr (w_addr),
		.depth  (depth)
	) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.factor    (factor),
		.twdl_num  (twdl_num),
		.twdl_den  (twdl_den),
		.in_val    (in_val),
		.in_addr   (in_addr),
		.din_real  (din_real),
		.din_imag  (din_imag),
		.out_val   (out_val),
		.out_addr  (out_addr),
		.dout_real (dout_real),
		.dout_imag (dout_imag)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic signed [31:0] expected,
			input logic signed [31:0] actual, input int tol);
		logic signed [31:0] diff;
		diff = expected - actual;
		if (diff < 0)
			diff = -diff;
		if ($isunknown(actual) || diff > tol) begin
			$display("[ERROR] %s expected 0x%h got 0x%h at cycle %0d",
				name, expected, actual, cycle);
			abort_run();
		end
	endtask

	task automatic add_case(input int r, input int fac, input int num, input int den,
			input int beats, input logic [7:0] gaps, input int lat);
		tab_factor[r] = fac;
		tab_num[r] = num;
		tab_den[r] = den;
		tab_beats[r] = beats;
		tab_gaps[r] = gaps;
		tab_lat[r] = lat;
	endtask

	// exponent of W seen by lane k
	function automatic int twiddle_power(input int fac, input int den, input int k);
		if (den == 1)
			return 0;
		// W^2 forced to unity, so W^3 is W and W^4 is unity
		if (fac == 2)
			return k % 2;
		return k;
	endfunction

	function automatic longint ideal_twiddle(input int num, input int den, input int p,
			input bit imag);
		real angle;
		real v;
		angle = 2.0 * pi * num * p / den;
		v = imag ? -$sin(angle) : $cos(angle);
		return $rtoi($floor(v * (1 << tw_frac) + 0.5));
	endfunction

	task automatic send_beat(input int r);
		logic [n_lanes-1:0][w_data-1:0] re_row;
		logic [n_lanes-1:0][w_data-1:0] im_row;
		logic [n_lanes-1:0] exact_row;
		int p;
		longint xr;
		longint xi;
		longint twr;
		longint twi;
		for (int k = 0; k < n_lanes; k++) begin
			// full scale only where no rotation happens
			if (tab_den[r] == 1) begin
				din_real[k] = $random(seed);
				din_imag[k] = $random(seed);
			end else begin
				din_real[k] = $random(seed) % 512;
				din_imag[k] = $random(seed) % 512;
			end
			xr = din_real[k];
			xi = din_imag[k];
			p = twiddle_power(tab_factor[r], tab_den[r], k);
			twr = ideal_twiddle(tab_num[r], tab_den[r], p, 1'b0);
			twi = ideal_twiddle(tab_num[r], tab_den[r], p, 1'b1);
			re_row[k] = w_data'((xr * twr - xi * twi + half_lsb) >>> tw_frac);
			im_row[k] = w_data'((xr * twi + xi * twr + half_lsb) >>> tw_frac);
			exact_row[k] = (p == 0);
		end
		in_val = 1'b1;
		in_addr = next_addr;
		due_q.push_back(cycle + tab_lat[r]);
		addr_q.push_back(next_addr);
		re_q.push_back(re_row);
		im_q.push_back(im_row);
		exact_q.push_back(exact_row);
		next_addr = next_addr + 1'b1;
	endtask

	// stimulus
	initial begin
		int sent;
		int slot;
		rst_n = 1'b0;
		factor = '0;
		twdl_num = '0;
		twdl_den = w_ratio'(1);
		in_val = 1'b0;
		in_addr = '0;
		for (int k = 0; k < n_lanes; k++) begin
			din_real[k] = '0;
			din_imag[k] = '0;
		end

		add_case(0, 5, 0, 1, 12, 8'hff, 1);
		add_case(1, 5, 1, 5, 16, 8'hff, twdl_lat);
		add_case(2, 4, 1, 4, 12, 8'hb5, twdl_lat);
		add_case(3, 3, 2, 3, 12, 8'h6d, twdl_lat);
		add_case(4, 2, 1, 8, 12, 8'hff, twdl_lat);
		add_case(5, 2, 3, 16, 10, 8'h93, twdl_lat);
		add_case(6, 5, 3, 5, 20, 8'hd7, twdl_lat);
		add_case(7, 3, 0, 1, 10, 8'h5a, 1);

		// gaps never stretch a beat past 8 slots
		cycle_limit = 4 + 4 * twdl_lat;
		for (int r = 0; r < n_cases; r++)
			cycle_limit += tab_beats[r] * 8 + cordic_lat + power_lat + 2 * twdl_lat + 4;

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int r = 0; r < n_cases; r++) begin
			@(posedge clk);
			#1;
			factor = 3'(tab_factor[r]);
			twdl_num = w_ratio'(tab_num[r]);
			twdl_den = w_ratio'(tab_den[r]);
			repeat (cordic_lat + power_lat) @(posedge clk);
			sent = 0;
			slot = 0;
			while (sent < tab_beats[r]) begin
				@(posedge clk);
				#1;
				if (tab_gaps[r][slot]) begin
					send_beat(r);
					sent++;
				end else begin
					in_val = 1'b0;
				end
				slot = (slot + 1) % 8;
			end
			@(posedge clk);
			#1;
			in_val = 1'b0;
			while (due_q.size() != 0)
				@(posedge clk);
			// let the valid line empty before the next ratio
			repeat (twdl_lat) @(posedge clk);
		end

		$display("Simulation PASSED");
		$finish;
	end

	// output monitor sampled away from the rising edge
	always @(negedge clk) begin : monitor
		logic [n_lanes-1:0][w_data-1:0] exp_re;
		logic [n_lanes-1:0][w_data-1:0] exp_im;
		logic [n_lanes-1:0] exact;
		int tol;
		if (rst_n) begin
			if (out_val && due_q.size() == 0) begin
				$display("out_val rose with no beat outstanding at cycle %0d", cycle);
				abort_run();
			end else if (out_val) begin
				exp_re = re_q.pop_front();
				exp_im = im_q.pop_front();
				exact = exact_q.pop_front();
				check_value("out_val cycle", due_q.pop_front(), cycle, 0);
				check_value("out_addr", addr_q.pop_front(), out_addr, 0);
				for (int k = 0; k < n_lanes; k++) begin
					tol = exact[k] ? 0 : rot_tol;
					check_value($sformatf("dout_real[%0d]", k), $signed(exp_re[k]),
						dout_real[k], tol);
					check_value($sformatf("dout_imag[%0d]", k), $signed(exp_im[k]),
						dout_imag[k], tol);
				end
			end else begin
				for (int k = 0; k < n_lanes; k++) begin
					check_value($sformatf("dout_real[%0d]", k), 0, dout_real[k], 0);
					check_value($sformatf("dout_imag[%0d]", k), 0, dout_imag[k], 0);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("timeout: stream did not drain within %0d cycles", cycle_limit);
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- verilog/fft_twdl_pkg.sv
`default_nettype none

package fft_twdl_pkg;

	// butterfly lanes per beat, up to radix 5
	localparam int n_lanes = 5;

	// twiddle format 2.14
	localparam int w_tw = 16;
	localparam int tw_frac = 14;
	localparam logic signed [w_tw-1:0] tw_one = w_tw'(1 << tw_frac);

	localparam int w_ratio = 12;

	localparam int cordic_iter = 16;
	// 1/1.647 in 2.14
	localparam logic signed [w_tw-1:0] cordic_gain_inv = 16'sd9948;
	// atan(2^-i), full turn is 2^16
	localparam logic [0:cordic_iter-1][15:0] cordic_atan = {
		16'd8192, 16'd4836, 16'd2555, 16'd1297, 16'd651, 16'd326, 16'd163, 16'd81,
		16'd41, 16'd20, 16'd10, 16'd5, 16'd3, 16'd1, 16'd1, 16'd0
	};

	localparam int cordic_lat = cordic_iter + 2;
	localparam int power_lat = 4;
	localparam int twdl_lat = cordic_lat + power_lat + 2;

endpackage

`default_nettype wire

//--- verilog/fft_twdl_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft_twdl_top import fft_twdl_pkg::*; #(
	parameter int w_data = 18,
	parameter int w_addr = 8,
	parameter int depth = 32
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire        [2:0]          factor,
	input  wire        [w_ratio-1:0]  twdl_num,
	input  wire        [w_ratio-1:0]  twdl_den,
	input  wire                       in_val,
	input  wire        [w_addr-1:0]   in_addr,
	input  wire signed [w_data-1:0]   din_real [n_lanes],
	input  wire signed [w_data-1:0]   din_imag [n_lanes],
	output logic                      out_val,
	output logic       [w_addr-1:0]   out_addr,
	output logic signed [w_data-1:0]  dout_real [n_lanes],
	output logic signed [w_data-1:0]  dout_imag [n_lanes]
);

	logic signed [w_tw-1:0] w1_real;
	logic signed [w_tw-1:0] w1_imag;
	logic signed [w_tw-1:0] tw_real [n_lanes];
	logic signed [w_tw-1:0] tw_imag [n_lanes];
	logic addr_rdreq;
	logic addr_sclr;

	twdl_cordic u_cordic (
		.clk         (clk),
		.rst_n       (rst_n),
		.numerator   (twdl_num),
		.denominator (twdl_den),
		.tw_real     (w1_real),
		.tw_imag     (w1_imag)
	);

	twdl_power_gen u_power (
		.clk     (clk),
		.factor  (factor),
		.w1_real (w1_real),
		.w1_imag (w1_imag),
		.tw_real (tw_real),
		.tw_imag (tw_imag)
	);

	twdl_rotator #(
		.w_data (w_data),
		.depth  (depth)
	) u_rotator (
		.clk        (clk),
		.rst_n      (rst_n),
		.twdl_den   (twdl_den),
		.in_val     (in_val),
		.din_real   (din_real),
		.din_imag   (din_imag),
		.tw_real    (tw_real),
		.tw_imag    (tw_imag),
		.out_val    (out_val),
		.dout_real  (dout_real),
		.dout_imag  (dout_imag),
		.addr_rdreq (addr_rdreq),
		.addr_sclr  (addr_sclr)
	);

	// output-order address rides alongside the lane data
	twdl_data_fifo #(
		.width (w_addr),
		.depth (depth)
	) u_addr_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.sclr  (addr_sclr),
		.wrreq (in_val),
		.rdreq (addr_rdreq),
		.data  (in_addr),
		.q     (out_addr)
	);

endmodule

`default_nettype wire

//--- verilog/twdl_cordic.sv
`timescale 1ns/1ps
`default_nettype none

module twdl_cordic import fft_twdl_pkg::*; (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire        [w_ratio-1:0]  numerator,
	input  wire        [w_ratio-1:0]  denominator,
	output logic signed [w_tw-1:0]    tw_real,
	output logic signed [w_tw-1:0]    tw_imag
);

	// working width with headroom over the 2.14 samples
	localparam int w_z = 18;

	logic [w_ratio:0] rem;
	logic [15:0] quo;

	logic signed [w_z-1:0] x_p [0:cordic_iter];
	logic signed [w_z-1:0] y_p [0:cordic_iter];
	logic signed [w_z-1:0] z_p [0:cordic_iter];
	logic [1:0] quad_p [0:cordic_iter];

	logic signed [w_tw-1:0] c_t;
	logic signed [w_tw-1:0] s_t;

	// restoring division, 16 quotient bits of numerator/denominator
	always_comb begin
		rem = {1'b0, numerator};
		quo = '0;
		for (int i = 15; i >= 0; i--) begin
			rem = rem << 1;
			if (rem >= {1'b0, denominator}) begin
				rem = rem - {1'b0, denominator};
				quo[i] = 1'b1;
			end
		end
	end

	// angle folded into the first quadrant
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x_p[0] <= '0;
			y_p[0] <= '0;
			z_p[0] <= '0;
			quad_p[0] <= '0;
		end else begin
			x_p[0] <= w_z'(cordic_gain_inv);
			y_p[0] <= '0;
			z_p[0] <= $signed({{(w_z-14){1'b0}}, quo[13:0]});
			quad_p[0] <= quo[15:14];
		end
	end

	for (genvar i = 0; i < cordic_iter; i++) begin : g_stage
		always_ff @(posedge clk) begin
			if (z_p[i][w_z-1]) begin
				x_p[i+1] <= x_p[i] + (y_p[i] >>> i);
				y_p[i+1] <= y_p[i] - (x_p[i] >>> i);
				z_p[i+1] <= z_p[i] + $signed({2'b00, cordic_atan[i]});
			end else begin
				x_p[i+1] <= x_p[i] - (y_p[i] >>> i);
				y_p[i+1] <= y_p[i] + (x_p[i] >>> i);
				z_p[i+1] <= z_p[i] - $signed({2'b00, cordic_atan[i]});
			end
			quad_p[i+1] <= quad_p[i];
		end
	end

	assign c_t = x_p[cordic_iter][w_tw-1:0];
	assign s_t = y_p[cordic_iter][w_tw-1:0];

	// restore quadrant, W = cos - j sin
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tw_real <= '0;
			tw_imag <= '0;
		end else begin
			case (quad_p[cordic_iter])
				2'd0: begin
					tw_real <= c_t;
					tw_imag <= -s_t;
				end
				2'd1: begin
					tw_real <= -s_t;
					tw_imag <= -c_t;
				end
				2'd2: begin
					tw_real <= -c_t;
					tw_imag <= s_t;
				end
				default: begin
					tw_real <= s_t;
					tw_imag <= c_t;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/twdl_data_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module twdl_data_fifo #(
	parameter int width = 36,
	parameter int depth = 32
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              sclr,
	input  wire              wrreq,
	input  wire              rdreq,
	input  wire  [width-1:0] data,
	output logic [width-1:0] q
);

	// depth is a power of two, pointers carry one wrap bit
	localparam int w_ptr = $clog2(depth);

	logic [width-1:0] mem [depth];
	logic [w_ptr:0] wr_ptr;
	logic [w_ptr:0] rd_ptr;
	logic empty;
	logic full;
	logic do_wr;
	logic do_rd;
	logic pass;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[w_ptr] != rd_ptr[w_ptr]) &&
		(wr_ptr[w_ptr-1:0] == rd_ptr[w_ptr-1:0]);
	assign do_wr = wrreq & ~full;
	// a read of an empty FIFO takes the word written in the same cycle
	assign pass = empty & do_wr & rdreq;
	assign do_rd = rdreq & (~empty | do_wr);

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr[w_ptr-1:0]] <= data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || sclr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			q <= '0;
		else if (do_rd)
			q <= pass ? data : mem[rd_ptr[w_ptr-1:0]];
	end

endmodule

`default_nettype wire

//--- verilog/twdl_power_gen.sv
`timescale 1ns/1ps
`default_nettype none

module twdl_power_gen import fft_twdl_pkg::*; (
	input  wire                     clk,
	input  wire        [2:0]        factor,
	input  wire signed [w_tw-1:0]   w1_real,
	input  wire signed [w_tw-1:0]   w1_imag,
	output logic signed [w_tw-1:0]  tw_real [n_lanes],
	output logic signed [w_tw-1:0]  tw_imag [n_lanes]
);

	localparam int w_p = 2 * w_tw;

	logic radix2;

	logic signed [w_p-1:0] p_rr, p_ii, p_ri;
	logic signed [w_p-1:0] p3_rr, p3_ii, p3_ri, p3_ir;
	logic signed [w_p-1:0] p4_rr, p4_ii, p4_ri;
	logic signed [w_p-1:0] w2_re_f, w2_im_f, w3_re_f, w3_im_f, w4_re_f, w4_im_f;

	logic signed [w_tw-1:0] w1_re_d [1:3];
	logic signed [w_tw-1:0] w1_im_d [1:3];
	logic signed [w_tw-1:0] w2_re, w2_im;
	logic signed [w_tw-1:0] w2_re_d, w2_im_d;

	assign radix2 = (factor == 3'd2);

	// W^2 partial products
	always_ff @(posedge clk) begin
		p_rr <= w1_real * w1_real;
		p_ii <= w1_imag * w1_imag;
		p_ri <= w1_real * w1_imag;
		w1_re_d[1] <= w1_real;
		w1_im_d[1] <= w1_imag;
	end

	assign w2_re_f = p_rr - p_ii;
	assign w2_im_f = p_ri <<< 1;

	// radix-2 pairs see unity on lane 2
	always_ff @(posedge clk) begin
		w2_re <= radix2 ? tw_one : w2_re_f[tw_frac+w_tw-1:tw_frac];
		w2_im <= radix2 ? '0 : w2_im_f[tw_frac+w_tw-1:tw_frac];
		w1_re_d[2] <= w1_re_d[1];
		w1_im_d[2] <= w1_im_d[1];
	end

	// W^3 = W^2 * W, W^4 = W^2 squared
	always_ff @(posedge clk) begin
		p3_rr <= w1_re_d[2] * w2_re;
		p3_ii <= w1_im_d[2] * w2_im;
		p3_ri <= w1_re_d[2] * w2_im;
		p3_ir <= w1_im_d[2] * w2_re;
		p4_rr <= w2_re * w2_re;
		p4_ii <= w2_im * w2_im;
		p4_ri <= w2_re * w2_im;
		w1_re_d[3] <= w1_re_d[2];
		w1_im_d[3] <= w1_im_d[2];
		w2_re_d <= w2_re;
		w2_im_d <= w2_im;
	end

	assign w3_re_f = p3_rr - p3_ii;
	assign w3_im_f = p3_ri + p3_ir;
	assign w4_re_f = p4_rr - p4_ii;
	assign w4_im_f = p4_ri <<< 1;

	always_ff @(posedge clk) begin
		tw_real[0] <= tw_one;
		tw_imag[0] <= '0;
		tw_real[1] <= w1_re_d[3];
		tw_imag[1] <= w1_im_d[3];
		tw_real[2] <= w2_re_d;
		tw_imag[2] <= w2_im_d;
		tw_real[3] <= radix2 ? w1_re_d[3] : w3_re_f[tw_frac+w_tw-1:tw_frac];
		tw_imag[3] <= radix2 ? w1_im_d[3] : w3_im_f[tw_frac+w_tw-1:tw_frac];
		tw_real[4] <= w4_re_f[tw_frac+w_tw-1:tw_frac];
		tw_imag[4] <= w4_im_f[tw_frac+w_tw-1:tw_frac];
	end

endmodule

`default_nettype wire

//--- verilog/twdl_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module twdl_rotator import fft_twdl_pkg::*; #(
	parameter int w_data = 18,
	parameter int depth = 32
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire        [w_ratio-1:0]  twdl_den,
	input  wire                       in_val,
	input  wire signed [w_data-1:0]   din_real [n_lanes],
	input  wire signed [w_data-1:0]   din_imag [n_lanes],
	input  wire signed [w_tw-1:0]     tw_real [n_lanes],
	input  wire signed [w_tw-1:0]     tw_imag [n_lanes],
	output logic                      out_val,
	output logic signed [w_data-1:0]  dout_real [n_lanes],
	output logic signed [w_data-1:0]  dout_imag [n_lanes],
	output logic                      addr_rdreq,
	output logic                      addr_sclr
);

	// 1.17 times 2.14 gives 34 bits
	localparam int w_prod = w_data + w_tw;
	localparam int w_ext = w_prod - w_data - tw_frac;

	logic bypass;
	logic [twdl_lat-1:0] valid_d;
	logic lane_rdreq;
	logic lane_sclr;
	logic signed [w_prod-1:0] sum_real [n_lanes];
	logic signed [w_prod-1:0] sum_imag [n_lanes];

	assign bypass = (twdl_den == w_ratio'(1));

	// valid_d[i] is in_val delayed by i+1 cycles
	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_d <= '0;
		else
			valid_d <= {valid_d[twdl_lat-2:0], in_val};
	end

	// last beat leaves the delay line with nothing behind it
	assign lane_sclr = valid_d[twdl_lat-1] & ~(|valid_d[twdl_lat-2:0]) & ~in_val;
	assign addr_sclr = lane_sclr;

	assign lane_rdreq = bypass ? in_val : valid_d[twdl_lat-4];
	assign addr_rdreq = bypass ? in_val : valid_d[twdl_lat-2];
	assign out_val = bypass ? valid_d[0] : valid_d[twdl_lat-1];

	for (genvar k = 0; k < n_lanes; k++) begin : g_lane
		logic [2*w_data-1:0] lane_q;
		logic signed [w_data-1:0] q_real;
		logic signed [w_data-1:0] q_imag;
		logic signed [w_prod-1:0] byp_real;
		logic signed [w_prod-1:0] byp_imag;

		twdl_data_fifo #(
			.width (2 * w_data),
			.depth (depth)
		) u_fifo (
			.clk   (clk),
			.rst_n (rst_n),
			.sclr  (lane_sclr),
			.wrreq (in_val),
			.rdreq (lane_rdreq),
			.data  ({din_real[k], din_imag[k]}),
			.q     (lane_q)
		);

		assign q_real = lane_q[2*w_data-1:w_data];
		assign q_imag = lane_q[w_data-1:0];

		// input sample scaled to product format
		assign byp_real = in_val ?
			{{w_ext{din_real[k][w_data-1]}}, din_real[k], {tw_frac{1'b0}}} : '0;
		assign byp_imag = in_val ?
			{{w_ext{din_imag[k][w_data-1]}}, din_imag[k], {tw_frac{1'b0}}} : '0;

		if (k == 0) begin : g_unity
			logic signed [w_data-1:0] d_real;
			logic signed [w_data-1:0] d_imag;

			// stands in for the product stage
			always_ff @(posedge clk) begin
				if (!rst_n || !valid_d[twdl_lat-3]) begin
					d_real <= '0;
					d_imag <= '0;
				end else begin
					d_real <= q_real;
					d_imag <= q_imag;
				end
			end

			always_ff @(posedge clk) begin
				if (!rst_n) begin
					sum_real[k] <= '0;
					sum_imag[k] <= '0;
				end else if (bypass) begin
					sum_real[k] <= byp_real;
					sum_imag[k] <= byp_imag;
				end else begin
					sum_real[k] <= {{w_ext{d_real[w_data-1]}}, d_real, {tw_frac{1'b0}}};
					sum_imag[k] <= {{w_ext{d_imag[w_data-1]}}, d_imag, {tw_frac{1'b0}}};
				end
			end
		end else begin : g_rot
			logic signed [w_prod-1:0] p_rr;
			logic signed [w_prod-1:0] p_ii;
			logic signed [w_prod-1:0] p_ri;
			logic signed [w_prod-1:0] p_ir;

			always_ff @(posedge clk) begin
				if (!rst_n || !valid_d[twdl_lat-3]) begin
					p_rr <= '0;
					p_ii <= '0;
					p_ri <= '0;
					p_ir <= '0;
				end else begin
					p_rr <= q_real * tw_real[k];
					p_ii <= q_imag * tw_imag[k];
					p_ri <= q_real * tw_imag[k];
					p_ir <= q_imag * tw_real[k];
				end
			end

			always_ff @(posedge clk) begin
				if (!rst_n) begin
					sum_real[k] <= '0;
					sum_imag[k] <= '0;
				end else if (bypass) begin
					sum_real[k] <= byp_real;
					sum_imag[k] <= byp_imag;
				end else begin
					sum_real[k] <= p_rr - p_ii;
					sum_imag[k] <= p_ri + p_ir;
				end
			end
		end

		// round half up at the last dropped bit
		assign dout_real[k] = sum_real[k][w_data+tw_frac-1:tw_frac] +
			w_data'(sum_real[k][tw_frac-1]);
		assign dout_imag[k] = sum_imag[k][w_data+tw_frac-1:tw_frac] +
			w_data'(sum_imag[k][tw_frac-1]);
	end

endmodule

`default_nettype wire
